//--- files.f
+incdir+hdl
hdl/stream_mux_pkg.sv
hdl/wb_mux_regs.sv
hdl/frame_switch.sv
hdl/out_skid_buffer.sv
hdl/stream_mux_top.sv
verif/tb_stream_mux.sv

//--- verif/tb_stream_mux.sv
`timescale 1ns/100ps
`default_nettype none

`include "stream_mux_config.svh"

module tb_stream_mux;

    // one admitted frame in switch order
    typedef struct packed {
        logic [`MUX_SEL_WIDTH-1:0] port;
        logic [13:0]               frame;
        logic [3:0]                len;
    } frame_rec_t;

    logic                                            clk;
    logic                                            rst;
    stream_mux_pkg::stream_beat_t [`MUX_S_COUNT-1:0] in_beat;
    logic [`MUX_S_COUNT-1:0]                         in_valid;
    logic [`MUX_S_COUNT-1:0]                         in_ready;
    stream_mux_pkg::stream_beat_t                    out_beat;
    logic                                            out_valid;
    logic                                            out_ready;
    stream_mux_pkg::wb_req_t                         wb_req;
    stream_mux_pkg::wb_rsp_t                         wb_rsp;

    // frame number of a port is its count of sent frames
    int                           frame_len [`MUX_S_COUNT][16];
    int                           frames_loaded [`MUX_S_COUNT];
    int                           frames_sent [`MUX_S_COUNT];
    int                           beat_idx [`MUX_S_COUNT];
    int                           len_pool [$];
    logic [31:0]                  rng_len = 32'd4249;
    logic [31:0]                  rng_drv = 32'd4249;
    logic                         gaps_on = 1'b0;
    logic                         bp_on = 1'b0;
    logic [`MUX_SEL_WIDTH-1:0]    exp_port = '0;
    logic [`MUX_S_COUNT-1:0]      allow_mask = '0;

    // scoreboard state
    frame_rec_t                   admit_q [$];
    int                           admit_count = 0;
    int                           out_idx = 0;
    int                           beats_out = 0;
    int                           frames_seen = 0;
    logic                         stall_seen = 1'b0;
    stream_mux_pkg::stream_beat_t held_beat;
    int                           limit_cycles = 0;

    stream_mux_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // reference beat with port, frame number and beat index packed in data
    function automatic stream_mux_pkg::stream_beat_t expected_beat(
        input logic [`MUX_SEL_WIDTH-1:0] port,
        input int                        frame,
        input int                        index,
        input int                        length
    );
        stream_mux_pkg::stream_beat_t b;
        b.data = {port, frame[13:0], index[15:0]};
        b.keep = '1;
        b.last = (index == length - 1);
        b.user = port[0];
        return b;
    endfunction

    task automatic abort_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_beat(input string name, input stream_mux_pkg::stream_beat_t exp,
                              input stream_mux_pkg::stream_beat_t act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    // classic single access ended by ack
    task automatic wb_cycle(input logic we, input logic [`WB_ADDR_WIDTH-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
        stream_mux_pkg::wb_req_t req;
        req     = '0;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we  = we;
        req.adr = addr;
        req.dat = wdata;
        req.sel = 4'hf;
        @(posedge clk);
        wb_req <= req;
        @(posedge clk);
        while (!wb_rsp.ack) begin
            @(posedge clk);
        end
        rdata = wb_rsp.dat;
        wb_req <= '0;
    endtask

    task automatic wb_write(input logic [`WB_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        wb_cycle(1'b1, addr, data, unused);
    endtask

    task automatic wb_read(input logic [`WB_ADDR_WIDTH-1:0] addr, output logic [31:0] data);
        wb_cycle(1'b0, addr, 32'd0, data);
    endtask

    task automatic set_ctrl(input logic en, input logic [`MUX_SEL_WIDTH-1:0] sel);
        wb_write(stream_mux_pkg::REG_CTRL, {28'd0, 1'b0, sel, en});
    endtask

    task automatic select_port(input int p);
        @(negedge clk);
        allow_mask = '0;
        allow_mask[p] = 1'b1;
        exp_port = p[`MUX_SEL_WIDTH-1:0];
        set_ctrl(1'b1, p[`MUX_SEL_WIDTH-1:0]);
    endtask

    task automatic add_frame(input int p, input int len);
        frame_len[p][frames_loaded[p]] = len;
        frames_loaded[p]++;
    endtask

    task automatic load_frames(input int p, input int n);
        @(negedge clk);
        for (int i = 0; i < n; i++) begin
            add_frame(p, len_pool.pop_front());
        end
    endtask

    // all frames of the port sent and all admitted beats out
    task automatic wait_port_done(input int p);
        while (frames_sent[p] != frames_loaded[p] || admit_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // input streams and out_ready
    always @(posedge clk) begin : drive_streams
        frame_rec_t rec;
        logic       done_beat;
        if (rst) begin
            in_valid  <= '0;
            out_ready <= 1'b0;
        end else begin
            for (int p = 0; p < `MUX_S_COUNT; p++) begin
                done_beat = in_valid[p] && in_ready[p];
                if (done_beat) begin
                    if (beat_idx[p] == 0) begin
                        rec.port  = p[`MUX_SEL_WIDTH-1:0];
                        rec.frame = frames_sent[p];
                        rec.len   = frame_len[p][frames_sent[p]];
                        admit_q.push_back(rec);
                        admit_count++;
                        check_word("admitted port", exp_port, p);
                    end
                    if (beat_idx[p] == frame_len[p][frames_sent[p]] - 1) begin
                        frames_sent[p]++;
                        beat_idx[p] = 0;
                    end else begin
                        beat_idx[p]++;
                    end
                end
                // a beat offered is held until taken
                if (!in_valid[p] || done_beat) begin
                    if (frames_sent[p] != frames_loaded[p]) begin
                        rng_drv = lcg_next(rng_drv);
                        in_valid[p] <= !gaps_on || (rng_drv[31:30] != 2'b00);
                        in_beat[p]  <= expected_beat(p[`MUX_SEL_WIDTH-1:0], frames_sent[p],
                                                     beat_idx[p], frame_len[p][frames_sent[p]]);
                    end else begin
                        in_valid[p] <= 1'b0;
                    end
                end
            end
            rng_drv = lcg_next(rng_drv);
            out_ready <= !bp_on || rng_drv[29];
        end
    end

    // output checker
    always @(posedge clk) begin : check_output
        frame_rec_t                   head;
        stream_mux_pkg::stream_beat_t exp;
        if (!rst) begin
            check_word("in_ready of unselected ports", 32'd0,
                       {28'd0, in_ready & ~allow_mask});
            if (stall_seen) begin
                check_word("out_valid", 32'd1, {31'd0, out_valid});
                check_beat("out_beat held", held_beat, out_beat);
            end
            if (out_valid && out_ready) begin
                if (admit_q.size() == 0) begin
                    $display("Output beat %h at %0t came with no frame admitted", out_beat, $time);
                    abort_run();
                end else begin
                    head = admit_q[0];
                    exp  = expected_beat(head.port, head.frame, out_idx, head.len);
                    check_beat("out_beat", exp, out_beat);
                    beats_out++;
                    if (out_idx == head.len - 1) begin
                        void'(admit_q.pop_front());
                        out_idx = 0;
                        frames_seen++;
                    end else begin
                        out_idx++;
                    end
                end
            end
            stall_seen = out_valid && !out_ready;
            held_beat  = out_beat;
        end
    end

    initial begin : watchdog
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, the tests did not finish", limit_cycles);
        abort_run();
    end

    initial begin : run_tests
        logic [31:0] rd;
        int          total_beats;
        int          start_count;
        int          out_before;
        int          adm_before;
        clk       = 1'b0;
        rst       = 1'b1;
        in_beat   = '0;
        in_valid  = '0;
        out_ready = 1'b0;
        wb_req    = '0;
        for (int p = 0; p < `MUX_S_COUNT; p++) begin
            frames_loaded[p] = 0;
            frames_sent[p]   = 0;
            beat_idx[p]      = 0;
        end

        // random lengths drawn up front plus the fixed frames of tests 3 and 5
        total_beats = 8 + 4 + 3 + 8 + 5 + 5;
        for (int i = 0; i < 26; i++) begin
            rng_len = lcg_next(rng_len);
            len_pool.push_back(int'(rng_len[18:16]) + 1);
            total_beats += len_pool[i];
        end
        limit_cycles = total_beats * 16 + 2000;

        repeat (16) @(posedge clk);
        rst <= 1'b0;

        // test 1 checks the reset state
        @(negedge clk);
        check_word("in_ready", 32'd0, {28'd0, in_ready});
        check_word("out_valid", 32'd0, {31'd0, out_valid});
        wb_read(stream_mux_pkg::REG_CTRL, rd);
        check_word("REG_CTRL", 32'd0, rd);
        wb_read(stream_mux_pkg::REG_FRAMES, rd);
        check_word("REG_FRAMES", 32'd0, rd);

        // test 2 selects every port in turn while all ports offer frames
        gaps_on = 1'b1;
        for (int p = 0; p < `MUX_S_COUNT; p++) begin
            load_frames(p, 3);
        end
        for (int p = 0; p < `MUX_S_COUNT; p++) begin
            select_port(p);
            wait_port_done(p);
        end

        // test 3 changes select in the middle of a frame
        gaps_on = 1'b0;
        @(negedge clk);
        add_frame(1, 8);
        add_frame(1, 4);
        add_frame(2, 3);
        start_count = admit_count;
        select_port(1);
        while (admit_count == start_count) begin
            @(negedge clk);
        end
        exp_port   = 2;
        allow_mask = 4'b0110;
        set_ctrl(1'b1, 2'd2);
        wait_port_done(2);
        check_word("frames left on port 1", 32'd1, frames_loaded[1] - frames_sent[1]);
        select_port(1);
        wait_port_done(1);

        // test 4 sends back to back frames under random back-pressure
        bp_on   = 1'b1;
        gaps_on = 1'b1;
        load_frames(3, 8);
        select_port(3);
        wait_port_done(3);
        load_frames(0, 6);
        select_port(0);
        wait_port_done(0);
        bp_on = 1'b0;

        // test 5 clears enable during a frame
        gaps_on = 1'b0;
        @(negedge clk);
        add_frame(2, 8);
        add_frame(2, 5);
        add_frame(2, 5);
        start_count = admit_count;
        select_port(2);
        while (admit_count == start_count) begin
            @(negedge clk);
        end
        set_ctrl(1'b0, 2'd2);
        rd = 32'hffff_ffff;
        while (rd[3]) begin
            wb_read(stream_mux_pkg::REG_CTRL, rd);
        end
        while (admit_q.size() != 0) begin
            @(negedge clk);
        end
        out_before = beats_out;
        adm_before = admit_count;
        repeat (50) @(negedge clk);
        check_word("output beats after disable", out_before, beats_out);
        check_word("frames admitted after disable", adm_before, admit_count);
        check_word("frames left on port 2", 32'd2, frames_loaded[2] - frames_sent[2]);
        wb_read(stream_mux_pkg::REG_CTRL, rd);
        check_word("REG_CTRL", 32'h4, rd);

        // test 6 covers the frame counter and an unused address
        check_word("frames seen", 32'd30, frames_seen);
        wb_read(stream_mux_pkg::REG_FRAMES, rd);
        check_word("REG_FRAMES", frames_seen, rd);
        wb_write(stream_mux_pkg::REG_FRAMES, 32'hdead_beef);
        wb_read(stream_mux_pkg::REG_FRAMES, rd);
        check_word("REG_FRAMES after clear", 32'd0, rd);
        wb_read(4'd5, rd);
        check_word("unused register", 32'd0, rd);

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/stream_mux_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "stream_mux_config.svh"

module stream_mux_top (
    input  wire                                              clk,
    input  wire                                              rst,
    input  wire stream_mux_pkg::stream_beat_t [`MUX_S_COUNT-1:0] in_beat,
    input  wire  [`MUX_S_COUNT-1:0]                          in_valid,
    output logic [`MUX_S_COUNT-1:0]                          in_ready,
    output stream_mux_pkg::stream_beat_t                     out_beat,
    output logic                                             out_valid,
    input  wire                                              out_ready,
    input  wire stream_mux_pkg::wb_req_t                     wb_req,
    output stream_mux_pkg::wb_rsp_t                          wb_rsp
);

    // control and status
    logic                          enable;
    logic [`MUX_SEL_WIDTH-1:0]     select;
    logic                          busy;
    logic                          frame_done;

    // switch to buffer
    stream_mux_pkg::stream_beat_t  sw_beat;
    logic                          sw_valid;
    logic                          buf_ready_early;

    wb_mux_regs regs0 (
        .clk        (clk),
        .rst        (rst),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .busy       (busy),
        .frame_done (frame_done),
        .enable     (enable),
        .select     (select)
    );

    frame_switch switch0 (
        .clk             (clk),
        .rst             (rst),
        .in_beat         (in_beat),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .enable          (enable),
        .select          (select),
        .buf_ready_early (buf_ready_early),
        .sw_beat         (sw_beat),
        .sw_valid        (sw_valid),
        .busy            (busy),
        .frame_done      (frame_done)
    );

    out_skid_buffer skid0 (
        .clk             (clk),
        .rst             (rst),
        .sw_beat         (sw_beat),
        .sw_valid        (sw_valid),
        .buf_ready_early (buf_ready_early),
        .out_beat        (out_beat),
        .out_valid       (out_valid),
        .out_ready       (out_ready)
    );

endmodule

`default_nettype wire

//--- hdl/out_skid_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module out_skid_buffer (
    input  wire                                clk,
    input  wire                                rst,
    input  wire stream_mux_pkg::stream_beat_t  sw_beat,
    input  wire                                sw_valid,
    output logic                               buf_ready_early,
    output stream_mux_pkg::stream_beat_t       out_beat,
    output logic                               out_valid,
    input  wire                                out_ready
);

    stream_mux_pkg::stream_beat_t  out_reg;
    stream_mux_pkg::stream_beat_t  temp_reg;
    logic                          out_valid_reg;
    logic                          out_valid_next;
    logic                          temp_valid_reg;
    logic                          temp_valid_next;
    logic                          in_ready_reg;
    logic                          store_in_to_out;
    logic                          store_in_to_temp;
    logic                          store_temp_to_out;

    // ready next cycle unless the temp register is about to fill
    assign buf_ready_early = out_ready | (~temp_valid_reg & (~out_valid_reg | ~sw_valid));

    always_comb begin
        out_valid_next    = out_valid_reg;
        temp_valid_next   = temp_valid_reg;
        store_in_to_out   = 1'b0;
        store_in_to_temp  = 1'b0;
        store_temp_to_out = 1'b0;

        if (in_ready_reg) begin
            if (out_ready || !out_valid_reg) begin
                // output free, input goes straight out
                out_valid_next  = sw_valid;
                store_in_to_out = 1'b1;
            end else begin
                // output stalled, park the beat in flight
                temp_valid_next  = sw_valid;
                store_in_to_temp = 1'b1;
            end
        end else if (out_ready) begin
            // drain the temp register
            out_valid_next    = temp_valid_reg;
            temp_valid_next   = 1'b0;
            store_temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_reg  <= 1'b0;
            temp_valid_reg <= 1'b0;
            in_ready_reg   <= 1'b0;
        end else begin
            out_valid_reg  <= out_valid_next;
            temp_valid_reg <= temp_valid_next;
            in_ready_reg   <= buf_ready_early;
        end
    end

    // beat payload
    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            out_reg <= sw_beat;
        end else if (store_temp_to_out) begin
            out_reg <= temp_reg;
        end
        if (store_in_to_temp) begin
            temp_reg <= sw_beat;
        end
    end

    assign out_beat  = out_reg;
    assign out_valid = out_valid_reg;

endmodule

`default_nettype wire

//--- hdl/frame_switch.sv
`timescale 1ns/100ps
`default_nettype none

`include "stream_mux_config.svh"

module frame_switch (
    input  wire                                              clk,
    input  wire                                              rst,
    input  wire stream_mux_pkg::stream_beat_t [`MUX_S_COUNT-1:0] in_beat,
    input  wire  [`MUX_S_COUNT-1:0]                          in_valid,
    output logic [`MUX_S_COUNT-1:0]                          in_ready,
    input  wire                                              enable,
    input  wire  [`MUX_SEL_WIDTH-1:0]                        select,
    input  wire                                              buf_ready_early,
    output stream_mux_pkg::stream_beat_t                     sw_beat,
    output logic                                             sw_valid,
    output logic                                             busy,
    output logic                                             frame_done
);

    stream_mux_pkg::switch_state_e   state;
    stream_mux_pkg::switch_state_e   state_next;
    logic [`MUX_SEL_WIDTH-1:0]       sel_reg;
    logic [`MUX_SEL_WIDTH-1:0]       sel_next;
    logic [`MUX_S_COUNT-1:0]         ready_reg;
    logic [`MUX_S_COUNT-1:0]         ready_next;
    stream_mux_pkg::stream_beat_t    cur_beat;
    logic                            cur_valid;
    logic                            cur_ready;
    logic                            accept;

    // latched port
    assign cur_beat  = in_beat[sel_reg];
    assign cur_valid = in_valid[sel_reg];
    assign cur_ready = ready_reg[sel_reg];

    // a completed input transfer inside a frame
    assign accept = cur_valid & cur_ready & (state == stream_mux_pkg::SW_FRAME);

    always_comb begin
        state_next = state;
        sel_next   = sel_reg;

        // end of frame on an accepted last beat
        if (accept && cur_beat.last) begin
            state_next = stream_mux_pkg::SW_IDLE;
        end

        // start of frame, take the current select
        if (state == stream_mux_pkg::SW_IDLE && enable && in_valid[select]) begin
            state_next = stream_mux_pkg::SW_FRAME;
            sel_next   = select;
        end

        // only the port of the next cycle's frame gets a ready
        ready_next = '0;
        ready_next[sel_next] = buf_ready_early & (state_next == stream_mux_pkg::SW_FRAME);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= stream_mux_pkg::SW_IDLE;
            sel_reg   <= '0;
            ready_reg <= '0;
        end else begin
            state     <= state_next;
            sel_reg   <= sel_next;
            ready_reg <= ready_next;
        end
    end

    assign in_ready   = ready_reg;
    assign sw_beat    = cur_beat;
    assign sw_valid   = accept;
    assign busy       = (state == stream_mux_pkg::SW_FRAME);
    assign frame_done = accept & cur_beat.last;

endmodule

`default_nettype wire

//--- hdl/wb_mux_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "stream_mux_config.svh"

module wb_mux_regs (
    input  wire                           clk,
    input  wire                           rst,
    input  wire stream_mux_pkg::wb_req_t  wb_req,
    output stream_mux_pkg::wb_rsp_t       wb_rsp,
    input  wire                           busy,
    input  wire                           frame_done,
    output logic                          enable,
    output logic [`MUX_SEL_WIDTH-1:0]     select
);

    logic                        ack_reg;
    logic [31:0]                 rd_data;
    logic [31:0]                 rd_data_reg;
    logic                        access;
    logic                        wr_en;
    logic                        enable_reg;
    logic [`MUX_SEL_WIDTH-1:0]   select_reg;
    logic [31:0]                 frame_count;
    stream_mux_pkg::reg_addr_e   addr;

    // new access only while ack is low, so ack lasts one cycle
    assign access = wb_req.cyc & wb_req.stb & ~ack_reg;
    assign wr_en  = access & wb_req.we;
    assign addr   = stream_mux_pkg::reg_addr_e'(wb_req.adr);

    // read mux
    always_comb begin
        case (addr)
            stream_mux_pkg::REG_CTRL: begin
                rd_data = {{(32-`MUX_SEL_WIDTH-2){1'b0}}, busy, select_reg, enable_reg};
            end
            stream_mux_pkg::REG_FRAMES: begin
                rd_data = frame_count;
            end
            default: begin
                rd_data = 32'd0;
            end
        endcase
    end

    // ack and bus handshake
    always_ff @(posedge clk) begin
        if (rst) begin
            ack_reg <= 1'b0;
        end else begin
            ack_reg <= access;
        end
    end

    // read data is captured with the access and returned with ack
    always_ff @(posedge clk) begin
        if (access) begin
            rd_data_reg <= rd_data;
        end
    end

    // control register, byte lane 0 only
    always_ff @(posedge clk) begin
        if (rst) begin
            enable_reg <= 1'b0;
            select_reg <= '0;
        end else if (wr_en && addr == stream_mux_pkg::REG_CTRL && wb_req.sel[0]) begin
            enable_reg <= wb_req.dat[0];
            select_reg <= wb_req.dat[`MUX_SEL_WIDTH:1];
        end
    end

    // completed frame counter
    always_ff @(posedge clk) begin
        if (rst) begin
            frame_count <= 32'd0;
        end else if (wr_en && addr == stream_mux_pkg::REG_FRAMES) begin
            // clear beats a same-cycle increment
            frame_count <= 32'd0;
        end else if (frame_done) begin
            frame_count <= frame_count + 32'd1;
        end
    end

    assign wb_rsp.ack = ack_reg;
    assign wb_rsp.dat = rd_data_reg;
    assign enable     = enable_reg;
    assign select     = select_reg;

endmodule

`default_nettype wire

//--- hdl/stream_mux_pkg.sv
`default_nettype none

`include "stream_mux_config.svh"

package stream_mux_pkg;

    // one beat of a stream, keep has one bit per byte
    typedef struct packed {
        logic [`MUX_DATA_WIDTH-1:0]   data;
        logic [`MUX_DATA_WIDTH/8-1:0] keep;
        logic                         last;
        logic                         user;
    } stream_beat_t;

    // wishbone classic, master to slave
    typedef struct packed {
        logic                      cyc;
        logic                      stb;
        logic                      we;
        logic [`WB_ADDR_WIDTH-1:0] adr;
        logic [31:0]               dat;
        logic [3:0]                sel;
    } wb_req_t;

    // wishbone classic, slave to master
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // frame switch states, SW_FRAME doubles as busy
    typedef enum logic {
        SW_IDLE  = 1'b0,
        SW_FRAME = 1'b1
    } switch_state_e;

    // register word addresses
    typedef enum logic [`WB_ADDR_WIDTH-1:0] {
        REG_CTRL   = 0,
        REG_FRAMES = 1
    } reg_addr_e;

endpackage

`default_nettype wire

//--- hdl/stream_mux_config.svh
`ifndef STREAM_MUX_CONFIG_SVH
`define STREAM_MUX_CONFIG_SVH

// number of input streams sharing the output
`define MUX_S_COUNT 4

// data bits per stream beat
`define MUX_DATA_WIDTH 32

// port select width, log2 of the port count
`define MUX_SEL_WIDTH 2

// wishbone word address width
`define WB_ADDR_WIDTH 4

`endif
